/* rob_core.f */
verilog/rob_cfg_pkg.sv
verilog/rob_types_pkg.sv
verilog/disp_if.sv
verilog/rob_cfg_regs.sv
verilog/rob_alloc_ptr.sv
verilog/rob_entry.sv
verilog/rob.sv
verilog/rob_top.sv
testbench/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds rob_tb with Verilator, runs it and searches the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f rob_core.f -o rob_sim \
  && ./obj_dir/rob_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb import rob_cfg_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  // rough length of the five tests in cycles, settle loops included.
  localparam int TEST_CYCLES = 14 + 70 + 25 + 35 + 60;
  localparam int WATCHDOG_NS = (2 * TEST_CYCLES + 10) * CLK_PERIOD;

  logic                                  i_clk;
  logic                                  i_reset;
  logic                                  i_disp_valid;
  logic [PC_W-1:0]                       i_disp_pc;
  logic [DISP_SIZE-1:0]                  i_disp_inst_valid;
  logic [DISP_SIZE-1:0][INST_W-1:0]      i_disp_inst;
  logic [DISP_SIZE-1:0]                  i_old_rd_valid;
  logic [DISP_SIZE-1:0][RNID_W-1:0]      i_old_rd_rnid;
  logic [CMT_BUS_SIZE-1:0]               i_done_valid;
  logic [CMT_BUS_SIZE-1:0][CMT_BLK_W-1:0] i_done_cmt_id;
  logic [CMT_BUS_SIZE-1:0][SLOT_W-1:0]   i_done_slot;
  logic                                  i_cfg_we;
  logic [CNT_W-1:0]                      i_cfg_limit;
  logic                                  i_cfg_halt;
  logic                                  o_credit;
  logic                                  o_commit_valid;
  logic [CMT_BLK_W-1:0]                  o_commit_cmt_id;
  logic [DISP_SIZE-1:0]                  o_commit_grp_id;
  logic [DISP_SIZE-1:0]                  o_commit_old_rd_valid;
  logic [DISP_SIZE-1:0][RNID_W-1:0]      o_commit_old_rnid;

  rob_top dut (.*);

  // ------------------------------
  // reference model
  // ------------------------------
  int                               credits;    // credits held by the dispatcher.
  int                               in_flight;
  int                               head_id;
  int                               tail_id;
  logic [CMT_BLK_W-1:0]             blk_q [$];  // block ids in dispatch order.
  int                               pend_q [$]; // id * DISP_SIZE + slot, not yet reported.
  logic [DISP_SIZE-1:0]             mdl_grp [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]             mdl_done [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]             mdl_ord [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0][RNID_W-1:0] mdl_rnid [CMT_BLK_SIZE];
  logic [CNT_W-1:0]                 mdl_limit;
  logic                             mdl_halt;
  logic                             exp_commit;
  logic [CMT_BLK_W-1:0]             exp_id;
  logic [DISP_SIZE-1:0]             exp_grp;
  logic [DISP_SIZE-1:0]             exp_ord;
  logic [DISP_SIZE-1:0][RNID_W-1:0] exp_rnid;
  int                               err_cnt = 0;
  int                               err_mark = 0;
  int                               test_cnt = 0;

  // the head retires once every valid slot is reported and halt is clear.
  assign exp_commit = (in_flight > 0) && !mdl_halt &&
                      ((mdl_grp[head_id] & ~mdl_done[head_id]) == '0);
  assign exp_id     = CMT_BLK_W'(head_id);
  assign exp_grp    = mdl_grp[head_id];
  assign exp_ord    = mdl_ord[head_id];
  assign exp_rnid   = mdl_rnid[head_id];

  always @(posedge i_clk) begin
    logic retire_now;
    retire_now = exp_commit;
    if (i_reset) begin
      credits   = 0;
      tail_id   = 0;
      blk_q.delete();
      mdl_limit = CNT_W'(CMT_BLK_SIZE);
      mdl_halt  = 1'b0;
    end else begin
      if (o_credit) begin
        credits++;
      end
      if (retire_now) begin
        void'(blk_q.pop_front());
      end
      for (int b = 0; b < CMT_BUS_SIZE; b++) begin
        if (i_done_valid[b]) begin
          mdl_done[i_done_cmt_id[b]][i_done_slot[b]] = 1'b1;
        end
      end
      if (i_disp_valid) begin
        credits--;  // the credit turns into an occupied entry.
        mdl_grp[tail_id]  = i_disp_inst_valid;
        mdl_done[tail_id] = '0;
        mdl_ord[tail_id]  = i_old_rd_valid;
        mdl_rnid[tail_id] = i_old_rd_rnid;
        blk_q.push_back(CMT_BLK_W'(tail_id));
        tail_id = (tail_id + 1) % CMT_BLK_SIZE;
      end
      if (i_cfg_we) begin
        if (i_cfg_limit == '0) begin
          mdl_limit = CNT_W'(1);
        end else if (i_cfg_limit > CNT_W'(CMT_BLK_SIZE)) begin
          mdl_limit = CNT_W'(CMT_BLK_SIZE);
        end else begin
          mdl_limit = i_cfg_limit;
        end
        mdl_halt = i_cfg_halt;
      end
    end
    in_flight = blk_q.size();
    head_id   = (in_flight > 0) ? int'(blk_q[0]) : 0;
  end

  task automatic note_mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    err_cnt++;
    $display("FAILED at %0t: %s got %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic note_error(input string msg);
    err_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> (!o_credit && !o_commit_valid))
    else note_error("credit or commit is active right after a reset cycle");
  a_commit_when: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid == exp_commit)
    else note_mismatch("o_commit_valid", $sampled(o_commit_valid), $sampled(exp_commit));
  a_commit_id: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid |-> (o_commit_cmt_id == exp_id))
    else note_mismatch("o_commit_cmt_id", $sampled(o_commit_cmt_id), $sampled(exp_id));
  a_commit_grp: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid |-> (o_commit_grp_id == exp_grp))
    else note_mismatch("o_commit_grp_id", $sampled(o_commit_grp_id), $sampled(exp_grp));
  a_commit_ord: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid |-> (o_commit_old_rd_valid == exp_ord))
    else note_mismatch("o_commit_old_rd_valid", $sampled(o_commit_old_rd_valid),
                       $sampled(exp_ord));
  a_commit_rnid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid |-> (o_commit_old_rnid == exp_rnid))
    else note_mismatch("o_commit_old_rnid", $sampled(o_commit_old_rnid), $sampled(exp_rnid));
  // the grant was decided against the limit of the cycle before the pulse.
  a_credit_limit: assert property (@(posedge i_clk) disable iff (i_reset)
    o_credit |-> ((credits + in_flight) < int'($past(mdl_limit))))
    else note_error("a credit was granted while the occupancy limit was reached");

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic dispatch_block(input logic [DISP_SIZE-1:0] grp);
    int cycles;
    cycles = 0;
    while (credits == 0 && cycles < 40) begin
      @(negedge i_clk);
      cycles++;
    end
    if (credits == 0) begin
      note_error("no credit arrived for a dispatch within 40 cycles");
    end else begin
      i_disp_valid      = 1'b1;
      i_disp_pc         = $urandom;
      i_disp_inst_valid = grp;
      i_old_rd_valid    = grp & DISP_SIZE'($urandom);
      for (int d = 0; d < DISP_SIZE; d++) begin
        i_disp_inst[d]   = $urandom;
        i_old_rd_rnid[d] = RNID_W'($urandom);
        if (grp[d]) begin
          pend_q.push_back(tail_id * DISP_SIZE + d);
        end
      end
      @(negedge i_clk);
      i_disp_valid = 1'b0;
    end
  endtask

  // reports pending slots in random order, one per bus and cycle, until keep are left.
  task automatic flush_dones(input int keep);
    int idx;
    while (pend_q.size() > keep) begin
      for (int b = 0; b < CMT_BUS_SIZE; b++) begin
        if (pend_q.size() > keep) begin
          idx              = $urandom_range(pend_q.size() - 1);
          i_done_valid[b]  = 1'b1;
          i_done_cmt_id[b] = CMT_BLK_W'(pend_q[idx] / DISP_SIZE);
          i_done_slot[b]   = SLOT_W'(pend_q[idx] % DISP_SIZE);
          pend_q.delete(idx);
        end
      end
      @(negedge i_clk);
      i_done_valid = '0;
    end
  endtask

  task automatic write_cfg(input int limit, input logic halt);
    i_cfg_we    = 1'b1;
    i_cfg_limit = CNT_W'(limit);
    i_cfg_halt  = halt;
    @(negedge i_clk);
    i_cfg_we = 1'b0;
  endtask

  task automatic settle(input int want);
    int cycles;
    cycles = 0;
    while ((in_flight != 0 || credits != want) && cycles < 60) begin
      @(negedge i_clk);
      cycles++;
    end
    assert (in_flight == 0 && credits == want)
      else note_error($sformatf("buffer did not drain to %0d credits in 60 cycles", want));
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(19));
    i_reset           = 1'b1;
    i_disp_valid      = 1'b0;
    i_disp_pc         = '0;
    i_disp_inst_valid = '0;
    i_disp_inst       = '0;
    i_old_rd_valid    = '0;
    i_old_rd_rnid     = '0;
    i_done_valid      = '0;
    i_done_cmt_id     = '0;
    i_done_slot       = '0;
    i_cfg_we          = 1'b0;
    i_cfg_limit       = '0;
    i_cfg_halt        = 1'b0;
    repeat (2) @(negedge i_clk);
    i_reset = 1'b0;

    for (int k = 0; k < CMT_BLK_SIZE + 4; k++) begin
      @(negedge i_clk);
      assert (o_credit == (k < CMT_BLK_SIZE))
        else note_mismatch("o_credit", o_credit, k < CMT_BLK_SIZE);
    end
    end_test("reset and credits");

    for (int r = 0; r < 3; r++) begin
      repeat (5) dispatch_block(DISP_SIZE'($urandom_range(1, 3)));
      flush_dones(0);
      settle(CMT_BLK_SIZE);
    end
    end_test("in-order retirement");

    dispatch_block('1);
    flush_dones(1);  // one slot stays open.
    repeat (6) @(negedge i_clk);
    flush_dones(0);
    settle(CMT_BLK_SIZE);
    end_test("completion gating");

    write_cfg(CMT_BLK_SIZE, 1'b1);
    repeat (3) dispatch_block(DISP_SIZE'($urandom_range(1, 3)));
    flush_dones(0);
    repeat (8) @(negedge i_clk);
    write_cfg(CMT_BLK_SIZE, 1'b0);
    settle(CMT_BLK_SIZE);
    end_test("halt back-pressure");

    // fill the ring first so that the lower limit only bites on returning credits.
    repeat (CMT_BLK_SIZE) dispatch_block(DISP_SIZE'($urandom_range(1, 3)));
    write_cfg(3, 1'b0);
    flush_dones(0);
    settle(3);
    write_cfg(0, 1'b0);
    repeat (3) dispatch_block(DISP_SIZE'($urandom_range(1, 3)));
    flush_dones(0);
    settle(1);
    write_cfg(CMT_BLK_SIZE, 1'b0);
    settle(CMT_BLK_SIZE);
    end_test("occupancy limit");

    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog/rob_top.sv */
`timescale 1ns/1ps

module rob_top import rob_cfg_pkg::*, rob_types_pkg::*; (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_disp_valid,
  input  logic [PC_W-1:0]                     i_disp_pc,
  input  logic [DISP_SIZE-1:0]                i_disp_inst_valid,
  input  logic [DISP_SIZE-1:0][INST_W-1:0]    i_disp_inst,
  input  logic [DISP_SIZE-1:0]                i_old_rd_valid,
  input  logic [DISP_SIZE-1:0][RNID_W-1:0]    i_old_rd_rnid,
  input  logic [CMT_BUS_SIZE-1:0]             i_done_valid,
  input  logic [CMT_BUS_SIZE-1:0][CMT_BLK_W-1:0] i_done_cmt_id,
  input  logic [CMT_BUS_SIZE-1:0][SLOT_W-1:0] i_done_slot,
  input  logic                                i_cfg_we,
  input  logic [CNT_W-1:0]                    i_cfg_limit,
  input  logic                                i_cfg_halt,
  output logic                                o_credit,
  output logic                                o_commit_valid,
  output logic [CMT_BLK_W-1:0]                o_commit_cmt_id,
  output logic [DISP_SIZE-1:0]                o_commit_grp_id,
  output logic [DISP_SIZE-1:0]                o_commit_old_rd_valid,
  output logic [DISP_SIZE-1:0][RNID_W-1:0]    o_commit_old_rnid
);

  logic [CNT_W-1:0] w_limit;
  logic             w_halt;
  done_rpt_t        w_done_rpt [CMT_BUS_SIZE];
  commit_blk_t      w_commit;

  // ----------------------------
  // dispatch group into the interface
  // ----------------------------
  disp_if u_disp ();

  assign u_disp.valid        = i_disp_valid;
  assign u_disp.pc_addr      = i_disp_pc;
  assign u_disp.old_rd_valid = i_old_rd_valid;

  for (genvar d_idx = 0; d_idx < DISP_SIZE; d_idx++) begin : g_disp
    assign u_disp.inst[d_idx]        = '{valid: i_disp_inst_valid[d_idx], inst: i_disp_inst[d_idx]};
    assign u_disp.old_rd_rnid[d_idx] = i_old_rd_rnid[d_idx];
  end

  for (genvar b_idx = 0; b_idx < CMT_BUS_SIZE; b_idx++) begin : g_done
    assign w_done_rpt[b_idx] = '{valid:  i_done_valid[b_idx],
                                 cmt_id: i_done_cmt_id[b_idx],
                                 slot:   i_done_slot[b_idx]};
  end

  rob_cfg_regs u_cfg (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_limit (i_cfg_limit),
    .i_cfg_halt  (i_cfg_halt),
    .o_limit     (w_limit),
    .o_halt      (w_halt)
  );

  rob u_rob (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .sc_disp    (u_disp),
    .i_done_rpt (w_done_rpt),
    .i_limit    (w_limit),
    .i_halt     (w_halt),
    .o_credit   (o_credit),
    .o_commit   (w_commit)
  );

  assign o_commit_valid        = w_commit.commit;
  assign o_commit_cmt_id       = w_commit.cmt_id;
  assign o_commit_grp_id       = w_commit.grp_id;
  assign o_commit_old_rd_valid = w_commit.old_rd_valid;
  assign o_commit_old_rnid     = w_commit.old_rnid;

endmodule

/* verilog/rob.sv */
`timescale 1ns/1ps

module rob import rob_cfg_pkg::*, rob_types_pkg::*; (
  input  logic             i_clk,
  input  logic             i_reset,
  disp_if.watch            sc_disp,
  input  done_rpt_t        i_done_rpt [CMT_BUS_SIZE],
  input  logic [CNT_W-1:0] i_limit,
  input  logic             i_halt,
  output logic             o_credit,
  output commit_blk_t      o_commit
);

  logic [CMT_BLK_W-1:0]  w_in_ptr;
  logic [CMT_BLK_W-1:0]  w_out_ptr;
  logic                  w_out_vld;
  logic [DISP_SIZE-1:0]  w_disp_grp_id;
  logic [CMT_BLK_SIZE-1:0] w_entry_all_done;
  logic [DISP_SIZE-1:0]  w_entry_done_grp_id [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]  w_entry_old_rd_valid [CMT_BLK_SIZE];
  logic [RNID_W-1:0]     w_entry_old_rd_rnid [CMT_BLK_SIZE][DISP_SIZE];

  // the head retires only when it is complete and retirement is not halted.
  assign w_out_vld = w_entry_all_done[w_out_ptr] & ~i_halt;

  rob_alloc_ptr u_ptr (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_in_vld  (sc_disp.valid),
    .i_out_vld (w_out_vld),
    .i_limit   (i_limit),
    .o_in_ptr  (w_in_ptr),
    .o_out_ptr (w_out_ptr),
    .o_credit  (o_credit)
  );

  for (genvar d_idx = 0; d_idx < DISP_SIZE; d_idx++) begin : g_disp
    assign w_disp_grp_id[d_idx] = sc_disp.inst[d_idx].valid;
  end

  // ----------------------------
  // entry array
  // ----------------------------
  for (genvar c_idx = 0; c_idx < CMT_BLK_SIZE; c_idx++) begin : g_entry
    rob_entry u_entry (
      .i_clk               (i_clk),
      .i_reset             (i_reset),
      .i_cmt_id            (CMT_BLK_W'(c_idx)),
      .i_load_valid        (sc_disp.valid && (w_in_ptr == CMT_BLK_W'(c_idx))),
      .i_load_pc_addr      (sc_disp.pc_addr),
      .i_load_inst         (sc_disp.inst),
      .i_load_grp_id       (w_disp_grp_id),
      .i_old_rd_valid      (sc_disp.old_rd_valid),
      .i_old_rd_rnid       (sc_disp.old_rd_rnid),
      .i_done_rpt          (i_done_rpt),
      .i_commit_finish     (w_out_vld && (w_out_ptr == CMT_BLK_W'(c_idx))),
      .o_block_all_done    (w_entry_all_done[c_idx]),
      .o_block_done_grp_id (w_entry_done_grp_id[c_idx]),
      .o_old_rd_valid      (w_entry_old_rd_valid[c_idx]),
      .o_old_rd_rnid       (w_entry_old_rd_rnid[c_idx])
    );
  end

  always_comb begin
    o_commit.commit       = w_out_vld;
    o_commit.cmt_id       = w_out_ptr;
    o_commit.grp_id       = w_entry_done_grp_id[w_out_ptr];
    o_commit.old_rd_valid = w_entry_old_rd_valid[w_out_ptr];
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_commit.old_rnid[d] = w_entry_old_rd_rnid[w_out_ptr][d];
    end
  end

endmodule

/* verilog/rob_entry.sv */
`timescale 1ns/1ps

module rob_entry import rob_cfg_pkg::*, rob_types_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic [CMT_BLK_W-1:0] i_cmt_id,
  input  logic                 i_load_valid,
  input  logic [PC_W-1:0]      i_load_pc_addr,
  input  disp_inst_t           i_load_inst [DISP_SIZE],
  input  logic [DISP_SIZE-1:0] i_load_grp_id,
  input  logic [DISP_SIZE-1:0] i_old_rd_valid,
  input  logic [RNID_W-1:0]    i_old_rd_rnid [DISP_SIZE],
  input  done_rpt_t            i_done_rpt [CMT_BUS_SIZE],
  input  logic                 i_commit_finish,
  output logic                 o_block_all_done,
  output logic [DISP_SIZE-1:0] o_block_done_grp_id,
  output logic [DISP_SIZE-1:0] o_old_rd_valid,
  output logic [RNID_W-1:0]    o_old_rd_rnid [DISP_SIZE]
);

  logic                 r_valid;
  logic [DISP_SIZE-1:0] r_grp_id;
  logic [DISP_SIZE-1:0] r_done_grp_id;
  logic [DISP_SIZE-1:0] w_done_hit;

  // the old destination registers are kept for the free list until retirement.
  logic [DISP_SIZE-1:0] r_old_rd_valid;
  logic [RNID_W-1:0]    r_old_rd_rnid [DISP_SIZE];

  // any done bus may name any slot of this block.
  always_comb begin
    w_done_hit = '0;
    for (int b = 0; b < CMT_BUS_SIZE; b++) begin
      if (i_done_rpt[b].valid && (i_done_rpt[b].cmt_id == i_cmt_id)) begin
        w_done_hit[i_done_rpt[b].slot] = 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_valid       <= 1'b0;
      r_grp_id      <= '0;
      r_done_grp_id <= '0;
    end else if (i_load_valid) begin
      r_valid       <= 1'b1;
      r_grp_id      <= i_load_grp_id;
      r_done_grp_id <= '0;  // a fresh block starts with nothing done.
    end else if (i_commit_finish) begin
      r_valid <= 1'b0;
    end else if (r_valid) begin
      r_done_grp_id <= r_done_grp_id | (w_done_hit & r_grp_id);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_old_rd_valid <= i_old_rd_valid;
      r_old_rd_rnid  <= i_old_rd_rnid;
    end
  end

  assign o_block_all_done    = r_valid && ((r_grp_id & ~r_done_grp_id) == '0);
  assign o_block_done_grp_id = r_done_grp_id;
  assign o_old_rd_valid      = r_old_rd_valid;
  assign o_old_rd_rnid       = r_old_rd_rnid;

endmodule

/* verilog/rob_alloc_ptr.sv */
`timescale 1ns/1ps

module rob_alloc_ptr import rob_cfg_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_in_vld,
  input  logic                 i_out_vld,
  input  logic [CNT_W-1:0]     i_limit,
  output logic [CMT_BLK_W-1:0] o_in_ptr,
  output logic [CMT_BLK_W-1:0] o_out_ptr,
  output logic                 o_credit
);

  logic [CMT_BLK_W-1:0] r_in_ptr;
  logic [CMT_BLK_W-1:0] r_out_ptr;
  logic [CNT_W-1:0]     r_occ_cnt;   // entries holding a block.
  logic [CNT_W-1:0]     r_cred_cnt;  // credits granted, not yet spent.
  logic                 r_credit;
  logic [CNT_W-1:0]     w_occ_next;
  logic [CNT_W-1:0]     w_cred_next;
  logic [CNT_W:0]       w_outstanding;
  logic                 w_grant;

  // ----------------------------
  // ring pointers
  // ----------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_in_vld) begin
        r_in_ptr <= (r_in_ptr == CMT_BLK_W'(CMT_BLK_SIZE - 1)) ? '0 : r_in_ptr + 1'b1;
      end
      if (i_out_vld) begin
        r_out_ptr <= (r_out_ptr == CMT_BLK_W'(CMT_BLK_SIZE - 1)) ? '0 : r_out_ptr + 1'b1;
      end
    end
  end

  // ----------------------------
  // credit return
  // ----------------------------
  // the credit pulsing this cycle is already counted in r_cred_cnt.
  assign w_outstanding = {1'b0, r_occ_cnt} + {1'b0, r_cred_cnt};
  assign w_grant       = w_outstanding < {1'b0, i_limit};

  always_comb begin
    w_occ_next = r_occ_cnt;
    if (i_in_vld && !i_out_vld) begin
      w_occ_next = r_occ_cnt + 1'b1;
    end else if (!i_in_vld && i_out_vld) begin
      w_occ_next = r_occ_cnt - 1'b1;
    end
  end

  // a dispatch moves one unit from the credit count to the occupancy count.
  always_comb begin
    w_cred_next = r_cred_cnt;
    if (w_grant && !i_in_vld) begin
      w_cred_next = r_cred_cnt + 1'b1;
    end else if (!w_grant && i_in_vld) begin
      w_cred_next = r_cred_cnt - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_occ_cnt  <= '0;
      r_cred_cnt <= '0;
      r_credit   <= 1'b0;
    end else begin
      r_occ_cnt  <= w_occ_next;
      r_cred_cnt <= w_cred_next;
      r_credit   <= w_grant;  // at most one pulse per cycle.
    end
  end

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;
  assign o_credit  = r_credit;

endmodule

/* verilog/rob_cfg_regs.sv */
`timescale 1ns/1ps

module rob_cfg_regs import rob_cfg_pkg::*; (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_cfg_we,
  input  logic [CNT_W-1:0] i_cfg_limit,
  input  logic             i_cfg_halt,
  output logic [CNT_W-1:0] o_limit,
  output logic             o_halt
);

  logic [CNT_W-1:0] r_limit;
  logic             r_halt;
  logic [CNT_W-1:0] w_limit_clamped;

  // a zero limit would never grant a credit, so it is read as one.
  always_comb begin
    if (i_cfg_limit == '0) begin
      w_limit_clamped = CNT_W'(1);
    end else if (i_cfg_limit > CNT_W'(CMT_BLK_SIZE)) begin
      w_limit_clamped = CNT_W'(CMT_BLK_SIZE);
    end else begin
      w_limit_clamped = i_cfg_limit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_limit <= CNT_W'(CMT_BLK_SIZE);  // full buffer by default.
      r_halt  <= 1'b0;
    end else if (i_cfg_we) begin
      r_limit <= w_limit_clamped;
      r_halt  <= i_cfg_halt;
    end
  end

  assign o_limit = r_limit;
  assign o_halt  = r_halt;

endmodule

/* verilog/disp_if.sv */
`timescale 1ns/1ps

interface disp_if import rob_cfg_pkg::*, rob_types_pkg::*; ();

  logic                 valid;  // one commit block is written per high cycle.
  logic [PC_W-1:0]      pc_addr;
  disp_inst_t           inst [DISP_SIZE];
  logic [DISP_SIZE-1:0] old_rd_valid;
  logic [RNID_W-1:0]    old_rd_rnid [DISP_SIZE];

  // the dispatcher side.
  modport source (
    output valid,
    output pc_addr,
    output inst,
    output old_rd_valid,
    output old_rd_rnid
  );

  // the buffer side, which only samples the group.
  modport watch (
    input valid,
    input pc_addr,
    input inst,
    input old_rd_valid,
    input old_rd_rnid
  );

endinterface

/* verilog/rob_types_pkg.sv */
package rob_types_pkg;

  import rob_cfg_pkg::*;

  // one dispatched instruction slot.
  typedef struct packed {
    logic              valid;
    logic [INST_W-1:0] inst;
  } disp_inst_t;

  // a completion from an execution unit, naming a block and a slot in it.
  typedef struct packed {
    logic                 valid;
    logic [CMT_BLK_W-1:0] cmt_id;
    logic [SLOT_W-1:0]    slot;
  } done_rpt_t;

  // ----------------------------
  // retirement record
  // ----------------------------
  // the free list reclaims old_rnid[d] when old_rd_valid[d] is set.
  typedef struct packed {
    logic                             commit;
    logic [CMT_BLK_W-1:0]             cmt_id;
    logic [DISP_SIZE-1:0]             grp_id;
    logic [DISP_SIZE-1:0]             old_rd_valid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] old_rnid;
  } commit_blk_t;

endpackage

/* verilog/rob_cfg_pkg.sv */
package rob_cfg_pkg;

  // ----------------------------
  // buffer geometry
  // ----------------------------
  localparam int DISP_SIZE    = 2;  // instruction slots per commit block.
  localparam int CMT_BLK_SIZE = 8;
  localparam int CMT_BLK_W    = 3;  // id width of one commit block.
  localparam int CNT_W        = 4;  // must hold CMT_BLK_SIZE itself.
  localparam int SLOT_W       = $clog2(DISP_SIZE);

  // ----------------------------
  // bus widths
  // ----------------------------
  localparam int CMT_BUS_SIZE = 2;  // number of done report buses.
  localparam int RNID_W       = 6;
  localparam int PC_W         = 32;
  localparam int INST_W       = 32;

endpackage
